/* arcade_pkg.sv */
// shared types and constants for the arcade host glue
// import with arcade_pkg::* inside a module, scoped names in port lists
`default_nettype none

package arcade_pkg;

	localparam int dl_addr_w  = 25;
	localparam int dl_byte_w  = 8;
	localparam int mem_addr_w = 23;
	localparam int mem_word_w = 16;

	typedef logic [dl_addr_w-1:0]  dl_addr_t;
	typedef logic [dl_byte_w-1:0]  dl_byte_t;  // also one game input port
	typedef logic [mem_addr_w-1:0] mem_addr_t; // word address on a memory port
	typedef logic [mem_word_w-1:0] mem_word_t;
	typedef logic [1:0]            byte_en_t;  // upper byte enable first

	// download index that carries rom data
	localparam dl_byte_t rom_index = 8'd0;

	typedef enum logic [1:0] {
		game_defender = 2'd0,
		game_colony7  = 2'd1,
		game_mayday   = 2'd2,
		game_jin      = 2'd3
	} game_t;

	typedef logic [11:0] ctrl_t;
	// bit positions inside ctrl_t
	localparam int ctrl_coin2       = 11;
	localparam int ctrl_coin1       = 10;
	localparam int ctrl_two_players = 9;
	localparam int ctrl_one_player  = 8;
	localparam int ctrl_fire_d      = 7;
	localparam int ctrl_fire_c      = 6;
	localparam int ctrl_fire_b      = 5;
	localparam int ctrl_fire_a      = 4;
	localparam int ctrl_up          = 3;
	localparam int ctrl_down        = 2;
	localparam int ctrl_left        = 1;
	localparam int ctrl_right       = 0;

	typedef logic [1:0] orient_t; // {left/right, landscape/portrait}

endpackage

`default_nettype wire

/* button_pulse.sv */
// stretches a rising edge of a cabinet button into a long pulse
// pulse rises 2 cycles after the edge, lasts PULSE_LEN cycles
`default_nettype none

module button_pulse #(
	parameter int PULSE_LEN = 1048575
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  btn,
	output logic pulse
);

	localparam int CNT_W = $clog2(PULSE_LEN + 1);

	logic             btn_q, btn_qq; // input sync and edge history
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_q  <= 1'b0;
			btn_qq <= 1'b0;
			count  <= '0;
		end else begin
			btn_q  <= btn;
			btn_qq <= btn_q;
			if (btn_q && !btn_qq)
				count <= CNT_W'(PULSE_LEN); // new edge restarts the pulse
			else if (count != '0)
				count <= count - CNT_W'(1);
		end
	end

	assign pulse = (count != '0);

endmodule

`default_nettype wire

/* input_mapper.sv */
// maps player controls and menu bits onto the three game input ports
// one registered mapping per supported game, latency one cycle
`default_nettype none

module input_mapper #(
	parameter int PULSE_LEN = 1048575
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  arcade_pkg::game_t    game,
	input  arcade_pkg::ctrl_t    ctrl,
	input  wire [2:0]            dip,
	input  wire                  btn_advance,
	input  wire                  btn_hs_reset,
	input  wire                  auto_up,
	output arcade_pkg::dl_byte_t input0,
	output arcade_pkg::dl_byte_t input1,
	output arcade_pkg::dl_byte_t input2,
	output logic                 mayday,
	output arcade_pkg::orient_t  orientation
);

	import arcade_pkg::*;

	logic     advance, hs_reset;
	logic     m_up, m_down, m_left, m_right;
	logic     m_fire_a, m_fire_b, m_fire_c, m_fire_d;
	logic     m_one_player, m_two_players, m_coin1, m_coin2;
	dl_byte_t in0_n, in1_n, in2_n;
	logic     mayday_n;
	orient_t  orient_n;

	button_pulse #(.PULSE_LEN(PULSE_LEN)) i_advance_pulse (
		.clk_sys (clk_sys),
		.reset   (reset),
		.btn     (btn_advance),
		.pulse   (advance)
	);

	button_pulse #(.PULSE_LEN(PULSE_LEN)) i_hs_reset_pulse (
		.clk_sys (clk_sys),
		.reset   (reset),
		.btn     (btn_hs_reset),
		.pulse   (hs_reset)
	);

	assign m_up          = ctrl[ctrl_up];
	assign m_down        = ctrl[ctrl_down];
	assign m_left        = ctrl[ctrl_left];
	assign m_right       = ctrl[ctrl_right];
	assign m_fire_a      = ctrl[ctrl_fire_a];
	assign m_fire_b      = ctrl[ctrl_fire_b];
	assign m_fire_c      = ctrl[ctrl_fire_c];
	assign m_fire_d      = ctrl[ctrl_fire_d];
	assign m_one_player  = ctrl[ctrl_one_player];
	assign m_two_players = ctrl[ctrl_two_players];
	assign m_coin1       = ctrl[ctrl_coin1];
	assign m_coin2       = ctrl[ctrl_coin2];

	always_comb begin
		in0_n    = '0;
		in1_n    = '0;
		in2_n    = '0;
		mayday_n = 1'b0;
		orient_n = 2'b10;
		case (game)
			game_defender: begin
				// rom board pia port a, bit 2 is the unused right coin
				in0_n = {3'b000, m_coin1, hs_reset, 1'b0, advance, auto_up};
				in1_n = {m_down, m_left | m_right, m_one_player, m_two_players,
					m_fire_d, m_fire_c, m_fire_b, m_fire_a};
				in2_n = {7'b0000000, m_up};
			end
			game_colony7: begin
				orient_n = 2'b01;
				in0_n = {3'b000, m_coin1, 2'b00, dip[1:0]}; // bonus and lives dips
				in1_n = {m_fire_b, m_fire_a, m_one_player, m_two_players,
					m_up, m_left, m_right, m_down};
				in2_n = {7'b0000000, m_fire_c};
			end
			game_mayday: begin
				mayday_n = 1'b1; // protection on
				in0_n = {2'b00, m_coin2, m_coin1, 1'b0, hs_reset, advance, auto_up};
				in1_n = {m_down, 1'b0, m_one_player, m_two_players,
					m_fire_b, m_fire_c, m_right, m_fire_a};
				in2_n = {7'b0000000, m_up};
			end
			default: begin // jin
				orient_n = 2'b11;
				in0_n = {3'b000, m_coin2, m_coin1, 3'b000};
				in1_n = {m_fire_b, m_fire_a, m_one_player, m_two_players,
					m_right, m_left, m_down, m_up};
				// level completed dips are active low, lives on bit 3
				in2_n = {1'b0, ~dip[2:1], 1'b0, dip[0], 3'b000};
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			input0      <= '0;
			input1      <= '0;
			input2      <= '0;
			mayday      <= 1'b0;
			orientation <= 2'b10;
		end else begin
			input0      <= in0_n;
			input1      <= in1_n;
			input2      <= in2_n;
			mayday      <= mayday_n;
			orientation <= orient_n;
		end
	end

endmodule

`default_nettype wire

/* rom_port_writer.sv */
// writes downloaded bytes inside [WIN_LO, WIN_HI) to one memory port
// four-phase req/ack, one byte per handshake, busy until it fully closes
`default_nettype none

module rom_port_writer #(
	parameter int WIN_LO = 0,
	parameter int WIN_HI = 29696
) (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   byte_strobe,
	input  arcade_pkg::dl_addr_t  byte_addr,
	input  arcade_pkg::dl_byte_t  byte_data,
	output logic                  busy,
	output logic                  mem_req,
	input  wire                   mem_ack,
	output arcade_pkg::mem_addr_t mem_addr,
	output arcade_pkg::byte_en_t  mem_be,
	output arcade_pkg::mem_word_t mem_data
);

	import arcade_pkg::*;

	localparam dl_addr_t WIN_SIZE = dl_addr_t'(WIN_HI - WIN_LO);

	typedef enum logic [1:0] {
		st_idle,
		st_request, // req high, waiting for ack
		st_release, // req dropped, waiting for ack low
		st_settle
	} state_t;

	state_t   state;
	dl_addr_t offset;
	logic     take;

	// addresses below WIN_LO wrap to large offsets and fall outside
	assign offset = byte_addr - dl_addr_t'(WIN_LO);
	assign take   = byte_strobe && (offset < WIN_SIZE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			mem_req <= 1'b0;
		end else begin
			case (state)
				st_idle:
					if (take) begin
						mem_req <= 1'b1;
						state   <= st_request;
					end
				st_request:
					if (mem_ack) begin
						mem_req <= 1'b0;
						state   <= st_release;
					end
				st_release:
					if (!mem_ack)
						state <= st_settle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// port fields, held stable for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && take) begin
			mem_addr <= offset[mem_addr_w:1];                 // word address in window
			mem_be   <= {byte_addr[0], ~byte_addr[0]};         // odd byte goes high
			mem_data <= {byte_data, byte_data};
		end
	end

	assign busy = (state != st_idle);

endmodule

`default_nettype wire

/* rom_load_ctrl.sv */
// finds rom bytes in the download stream and hands them to the writers
// also drives back-pressure, the loaded flag and the core reset
`default_nettype none

module rom_load_ctrl (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  dl_active,
	input  arcade_pkg::dl_byte_t dl_index,
	input  wire                  dl_wr,
	input  arcade_pkg::dl_addr_t dl_addr,
	input  arcade_pkg::dl_byte_t dl_data,
	input  wire                  user_reset,
	input  wire                  main_busy,
	input  wire                  snd_busy,
	output logic                 byte_strobe,
	output arcade_pkg::dl_addr_t byte_addr,
	output arcade_pkg::dl_byte_t byte_data,
	output logic                 dl_ready,
	output logic                 rom_loaded,
	output logic                 core_reset
);

	import arcade_pkg::*;

	logic wr_q;      // dl_wr one cycle late
	logic active_q;
	logic rom_sel;
	logic end_seen;  // download has finished

	assign rom_sel = dl_active && (dl_index == rom_index);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q        <= 1'b0;
			byte_strobe <= 1'b0;
		end else begin
			wr_q        <= dl_wr;
			byte_strobe <= rom_sel && dl_wr && !wr_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_sel && dl_wr && !wr_q) begin
			byte_addr <= dl_addr;
			byte_data <= dl_data;
		end
	end

	// both writers see the strobe, so wait for both to finish
	assign dl_ready = !(byte_strobe || main_busy || snd_busy);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q   <= 1'b0;
			end_seen   <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			active_q <= dl_active;
			if (active_q && !dl_active)
				end_seen <= 1'b1;
			if (end_seen && dl_ready)
				rom_loaded <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			core_reset <= 1'b1;
		else
			core_reset <= user_reset || dl_active || !rom_loaded;
	end

endmodule

`default_nettype wire

/* core_host_glue.sv */
// host side glue of the arcade core: rom download to two memory ports,
// core reset sequencing and control mapping for the selected game
`default_nettype none

module core_host_glue #(
	parameter int PULSE_LEN = 1048575,
	parameter int SND_BASE  = 29696,  // 7400 hex
	parameter int SND_END   = 31744
) (
	input  wire                   clk_sys,
	input  wire                   reset,
	// download from the menu controller
	input  wire                   dl_active,
	input  arcade_pkg::dl_byte_t  dl_index,
	input  wire                   dl_wr,
	input  arcade_pkg::dl_addr_t  dl_addr,
	input  arcade_pkg::dl_byte_t  dl_data,
	output logic                  dl_ready,
	input  wire                   user_reset,
	output logic                  rom_loaded,
	output logic                  core_reset,
	// main cpu rom port
	output logic                  main_req,
	input  wire                   main_ack,
	output arcade_pkg::mem_addr_t main_addr,
	output arcade_pkg::byte_en_t  main_be,
	output arcade_pkg::mem_word_t main_data,
	// sound cpu rom port
	output logic                  snd_req,
	input  wire                   snd_ack,
	output arcade_pkg::mem_addr_t snd_addr,
	output arcade_pkg::byte_en_t  snd_be,
	output arcade_pkg::mem_word_t snd_data,
	// controls
	input  arcade_pkg::game_t     game,
	input  arcade_pkg::ctrl_t     ctrl,
	input  wire [2:0]             dip,
	input  wire                   btn_advance,
	input  wire                   btn_hs_reset,
	input  wire                   auto_up,
	output arcade_pkg::dl_byte_t  input0,
	output arcade_pkg::dl_byte_t  input1,
	output arcade_pkg::dl_byte_t  input2,
	output logic                  mayday,
	output arcade_pkg::orient_t   orientation
);

	import arcade_pkg::*;

	logic     byte_strobe;
	dl_addr_t byte_addr;
	dl_byte_t byte_data;
	logic     main_busy, snd_busy;

	input_mapper #(.PULSE_LEN(PULSE_LEN)) i_input_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game         (game),
		.ctrl         (ctrl),
		.dip          (dip),
		.btn_advance  (btn_advance),
		.btn_hs_reset (btn_hs_reset),
		.auto_up      (auto_up),
		.input0       (input0),
		.input1       (input1),
		.input2       (input2),
		.mayday       (mayday),
		.orientation  (orientation)
	);

	rom_port_writer #(.WIN_LO(0), .WIN_HI(SND_BASE)) i_main_writer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.byte_strobe (byte_strobe),
		.byte_addr   (byte_addr),
		.byte_data   (byte_data),
		.busy        (main_busy),
		.mem_req     (main_req),
		.mem_ack     (main_ack),
		.mem_addr    (main_addr),
		.mem_be      (main_be),
		.mem_data    (main_data)
	);

	rom_port_writer #(.WIN_LO(SND_BASE), .WIN_HI(SND_END)) i_snd_writer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.byte_strobe (byte_strobe),
		.byte_addr   (byte_addr),
		.byte_data   (byte_data),
		.busy        (snd_busy),
		.mem_req     (snd_req),
		.mem_ack     (snd_ack),
		.mem_addr    (snd_addr),
		.mem_be      (snd_be),
		.mem_data    (snd_data)
	);

	rom_load_ctrl i_rom_load_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.user_reset  (user_reset),
		.main_busy   (main_busy),
		.snd_busy    (snd_busy),
		.byte_strobe (byte_strobe),
		.byte_addr   (byte_addr),
		.byte_data   (byte_data),
		.dl_ready    (dl_ready),
		.rom_loaded  (rom_loaded),
		.core_reset  (core_reset)
	);

endmodule

`default_nettype wire

/* tb_core_host_glue.sv */
// self-checking testbench for the arcade host glue
// random rom download into two handshaking memory models, then control and button checks
`default_nettype none

// answers one four-phase port with random ack delays and records every write
module mem_port_model #(
	parameter int SLOTS = 96,
	parameter int SEED  = 1
) (
	input  wire                   clk_sys,
	input  wire                   req,
	output logic                  ack,
	input  arcade_pkg::mem_addr_t addr,
	input  arcade_pkg::byte_en_t  be,
	input  arcade_pkg::mem_word_t data
);
	timeunit 1ns;
	timeprecision 100ps;

	import arcade_pkg::*;

	mem_word_t words[SLOTS];   // one slot per byte address in the window
	byte_en_t  enables[SLOTS];
	int        hits[SLOTS];
	int        writes;
	int        seed;
	int        delay;
	int        slot;

	initial begin
		ack    = 1'b0;
		writes = 0;
		seed   = SEED;
		for (int i = 0; i < SLOTS; i++) begin
			words[i]   = '0;
			enables[i] = '0;
			hits[i]    = 0;
		end
		forever begin
			@(posedge clk_sys);
			#2;
			if (req) begin
				delay = $random(seed) & 7;
				repeat (delay) begin
					@(posedge clk_sys);
					#2;
				end
				slot = 2 * int'(addr) + int'(be[1]); // upper lane holds the odd byte
				if (slot < SLOTS) begin
					words[slot]   = data;
					enables[slot] = be;
					hits[slot]    = hits[slot] + 1;
				end
				writes = writes + 1;
				ack = 1'b1;
				do begin
					@(posedge clk_sys);
					#2;
				end while (req);
				ack = 1'b0;
			end
		end
	end

endmodule

module tb_core_host_glue;
	timeunit 1ns;
	timeprecision 100ps;

	import arcade_pkg::*;

	localparam int pulse_len   = 40;
	localparam int snd_base    = 96;
	localparam int snd_end     = 128;
	localparam int map_tests   = 200;
	localparam int cycle_limit = 160 * 20 + map_tests * 2 + 4 * (pulse_len + 10) + 500;
	localparam int seed_init   = 32'hf757_86dc;

	logic      clk_sys, reset;
	logic      dl_active, dl_wr, dl_ready;
	dl_byte_t  dl_index, dl_data;
	dl_addr_t  dl_addr;
	logic      user_reset, rom_loaded, core_reset;
	logic      main_req, main_ack, snd_req, snd_ack;
	mem_addr_t main_addr, snd_addr;
	byte_en_t  main_be, snd_be;
	mem_word_t main_data, snd_data;
	game_t     game;
	ctrl_t     ctrl;
	logic [2:0] dip;
	logic      btn_advance, btn_hs_reset, auto_up;
	dl_byte_t  input0, input1, input2;
	logic      mayday;
	orient_t   orientation;

	int        seed;
	int        cycles;
	dl_byte_t  rom_image[snd_end];

	core_host_glue #(
		.PULSE_LEN (pulse_len),
		.SND_BASE  (snd_base),
		.SND_END   (snd_end)
	) i_core_host_glue (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_ready     (dl_ready),
		.user_reset   (user_reset),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset),
		.main_req     (main_req),
		.main_ack     (main_ack),
		.main_addr    (main_addr),
		.main_be      (main_be),
		.main_data    (main_data),
		.snd_req      (snd_req),
		.snd_ack      (snd_ack),
		.snd_addr     (snd_addr),
		.snd_be       (snd_be),
		.snd_data     (snd_data),
		.game         (game),
		.ctrl         (ctrl),
		.dip          (dip),
		.btn_advance  (btn_advance),
		.btn_hs_reset (btn_hs_reset),
		.auto_up      (auto_up),
		.input0       (input0),
		.input1       (input1),
		.input2       (input2),
		.mayday       (mayday),
		.orientation  (orientation)
	);

	mem_port_model #(.SLOTS(snd_base), .SEED(seed_init)) i_main_mem (
		.clk_sys (clk_sys),
		.req     (main_req),
		.ack     (main_ack),
		.addr    (main_addr),
		.be      (main_be),
		.data    (main_data)
	);

	mem_port_model #(.SLOTS(snd_end - snd_base), .SEED(seed_init + 1)) i_snd_mem (
		.clk_sys (clk_sys),
		.req     (snd_req),
		.ack     (snd_ack),
		.addr    (snd_addr),
		.be      (snd_be),
		.data    (snd_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped responding", cycles);
		$display("Some tests failed");
		$fatal(1);
	end

	// a byte in flight must keep the host stalled
	initial begin
		do @(negedge clk_sys);
		while (reset || !dl_ready || !(main_req || main_ack || snd_req || snd_ack));
		$display("error at %0t ns: dl_ready is high while a memory handshake is open", $time);
		$display("Some tests failed");
		$fatal(1);
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2; // drive and sample point
	endtask

	task automatic wait_ready();
		while (!dl_ready)
			next_cycle();
	endtask

	task automatic send_byte(input int addr, input dl_byte_t data);
		wait_ready();
		dl_addr = dl_addr_t'(addr);
		dl_data = data;
		dl_wr   = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		next_cycle();
	endtask

	// cabinet wiring per game, bit by bit
	function automatic void expected_inputs(input game_t g, input ctrl_t c,
		input logic [2:0] d, input logic au, input logic adv, input logic hs,
		output dl_byte_t e0, output dl_byte_t e1, output dl_byte_t e2,
		output logic e_mayday, output orient_t e_orient);
		e0       = '0;
		e1       = '0;
		e2       = '0;
		e_mayday = 1'b0;
		e_orient = 2'b10;
		case (g)
			game_defender: begin
				e0[0] = au;
				e0[1] = adv;
				e0[3] = hs;
				e0[4] = c[ctrl_coin1];
				e1[0] = c[ctrl_fire_a];
				e1[1] = c[ctrl_fire_b];
				e1[2] = c[ctrl_fire_c];
				e1[3] = c[ctrl_fire_d];
				e1[4] = c[ctrl_two_players];
				e1[5] = c[ctrl_one_player];
				e1[6] = c[ctrl_left] | c[ctrl_right]; // reverse
				e1[7] = c[ctrl_down];
				e2[0] = c[ctrl_up];
			end
			game_colony7: begin
				e_orient = 2'b01;
				e0[1:0]  = d[1:0];
				e0[4]    = c[ctrl_coin1];
				e1[0]    = c[ctrl_down];
				e1[1]    = c[ctrl_right];
				e1[2]    = c[ctrl_left];
				e1[3]    = c[ctrl_up];
				e1[4]    = c[ctrl_two_players];
				e1[5]    = c[ctrl_one_player];
				e1[6]    = c[ctrl_fire_a];
				e1[7]    = c[ctrl_fire_b];
				e2[0]    = c[ctrl_fire_c];
			end
			game_mayday: begin
				e_mayday = 1'b1;
				e0[0] = au;
				e0[1] = adv;
				e0[2] = hs;
				e0[4] = c[ctrl_coin1];
				e0[5] = c[ctrl_coin2];
				e1[0] = c[ctrl_fire_a];
				e1[1] = c[ctrl_right];
				e1[2] = c[ctrl_fire_c];
				e1[3] = c[ctrl_fire_b];
				e1[4] = c[ctrl_two_players];
				e1[5] = c[ctrl_one_player];
				e1[7] = c[ctrl_down];
				e2[0] = c[ctrl_up];
			end
			default: begin
				e_orient = 2'b11;
				e0[3] = c[ctrl_coin1];
				e0[4] = c[ctrl_coin2];
				e1[0] = c[ctrl_up];
				e1[1] = c[ctrl_down];
				e1[2] = c[ctrl_left];
				e1[3] = c[ctrl_right];
				e1[4] = c[ctrl_two_players];
				e1[5] = c[ctrl_one_player];
				e1[6] = c[ctrl_fire_a];
				e1[7] = c[ctrl_fire_b];
				e2[3] = d[0];
				e2[5] = ~d[1];
				e2[6] = ~d[2];
			end
		endcase
	endfunction

	task automatic compare_mapping(input logic adv, input logic hs);
		dl_byte_t e0, e1, e2;
		logic     e_mayday;
		orient_t  e_orient;
		expected_inputs(game, ctrl, dip, auto_up, adv, hs, e0, e1, e2, e_mayday, e_orient);
		check_value("input0", 32'(input0), 32'(e0));
		check_value("input1", 32'(input1), 32'(e1));
		check_value("input2", 32'(input2), 32'(e2));
		check_value("mayday", 32'(mayday), 32'(e_mayday));
		check_value("orientation", 32'(orientation), 32'(e_orient));
	endtask

	// pulse shows on input0 from 3 cycles after the press, for pulse_len cycles
	task automatic press_button(input logic use_hs);
		logic on;
		if (use_hs)
			btn_hs_reset = 1'b1;
		else
			btn_advance = 1'b1;
		for (int k = 1; k <= pulse_len + 8; k++) begin
			next_cycle();
			if (k == 4) begin
				btn_advance  = 1'b0;
				btn_hs_reset = 1'b0;
			end
			on = (k >= 3) && (k < 3 + pulse_len);
			compare_mapping(on && !use_hs, on && use_hs);
		end
	endtask

	initial begin
		seed         = seed_init;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		user_reset   = 1'b0;
		game         = game_defender;
		ctrl         = '0;
		dip          = '0;
		btn_advance  = 1'b0;
		btn_hs_reset = 1'b0;
		auto_up      = 1'b0;
		repeat (4) next_cycle();
		check_value("main_req", 32'(main_req), 32'd0);
		check_value("snd_req", 32'(snd_req), 32'd0);
		check_value("dl_ready", 32'(dl_ready), 32'd1);
		check_value("rom_loaded", 32'(rom_loaded), 32'd0);
		check_value("core_reset", 32'(core_reset), 32'd1);
		reset = 1'b0;
		next_cycle();

		// rom download, main image first then sound image
		dl_index  = rom_index;
		dl_active = 1'b1;
		next_cycle();
		for (int a = 0; a < snd_end; a++) begin
			rom_image[a] = dl_byte_t'($random(seed));
			send_byte(a, rom_image[a]);
		end
		wait_ready();
		check_value("rom_loaded", 32'(rom_loaded), 32'd0);
		check_value("core_reset", 32'(core_reset), 32'd1);
		for (int a = 0; a < snd_base; a++) begin
			check_value("main write count", 32'(i_main_mem.hits[a]), 32'd1);
			check_value("main_data", 32'(i_main_mem.words[a]),
				32'({rom_image[a], rom_image[a]}));
			check_value("main_be", 32'(i_main_mem.enables[a]), a[0] ? 32'd2 : 32'd1);
		end
		for (int a = snd_base; a < snd_end; a++) begin
			check_value("snd write count", 32'(i_snd_mem.hits[a - snd_base]), 32'd1);
			check_value("snd_data", 32'(i_snd_mem.words[a - snd_base]),
				32'({rom_image[a], rom_image[a]}));
			check_value("snd_be", 32'(i_snd_mem.enables[a - snd_base]), a[0] ? 32'd2 : 32'd1);
		end
		check_value("main writes", 32'(i_main_mem.writes), 32'(snd_base));
		check_value("snd writes", 32'(i_snd_mem.writes), 32'(snd_end - snd_base));

		dl_active = 1'b0;
		while (!rom_loaded)
			next_cycle();
		next_cycle();
		check_value("core_reset", 32'(core_reset), 32'd0);
		user_reset = 1'b1;
		next_cycle();
		check_value("core_reset", 32'(core_reset), 32'd1);
		user_reset = 1'b0;
		next_cycle();
		check_value("core_reset", 32'(core_reset), 32'd0);
		dl_index  = 8'd1; // not rom, no bytes follow
		dl_active = 1'b1;
		next_cycle();
		check_value("core_reset", 32'(core_reset), 32'd1);
		dl_active = 1'b0;
		dl_index  = rom_index;
		next_cycle();
		check_value("core_reset", 32'(core_reset), 32'd0);
		check_value("rom_loaded", 32'(rom_loaded), 32'd1);

		for (int n = 0; n < map_tests; n++) begin
			game    = game_t'(2'($random(seed)));
			ctrl    = ctrl_t'($random(seed));
			dip     = 3'($random(seed));
			auto_up = 1'($random(seed));
			next_cycle();
			compare_mapping(1'b0, 1'b0);
		end

		game    = game_defender;
		ctrl    = '0;
		dip     = '0;
		auto_up = 1'b0;
		next_cycle();
		for (int n = 0; n < 4; n++)
			press_button(n[0]); // advance, then high score reset
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
arcade_pkg.sv
button_pulse.sv
input_mapper.sv
rom_port_writer.sv
rom_load_ctrl.sv
core_host_glue.sv
tb_core_host_glue.sv

/* Makefile */
TOP = tb_core_host_glue

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
